// File: common/sdram_settings.svh
/* frame step map, cas latency, refresh interval
   and power-up countdown values */
`ifndef SDRAM_SETTINGS_SVH
`define SDRAM_SETTINGS_SVH

// fixed frame, two bank slots interleaved
`define SDRAM_FRAME_STEPS 8
`define SDRAM_CAS_LATENCY 3

// slot 0, banks 0/1 (rom, wram)
`define SDRAM_RAS0_STEP 3'd0
`define SDRAM_CAS0_STEP 3'd3 // tRCD of 3 clocks
`define SDRAM_CAP0_STEP 3'd7

// slot 1, bank 3 (vram), capture falls in the next frame
`define SDRAM_RAS1_STEP 3'd4
`define SDRAM_CAS1_STEP 3'd7
`define SDRAM_CAP1_STEP 3'd3

`define SDRAM_REFRESH_CYCLES 11'd1000 // 64ms / 8192 rows

// power-up countdown, one tick per frame
`define SDRAM_INIT_FRAMES    5'd31
`define SDRAM_INIT_PRECHARGE 5'd15
`define SDRAM_INIT_REFRESH_A 5'd10
`define SDRAM_INIT_REFRESH_B 5'd8
`define SDRAM_INIT_MODE      5'd2

// single writes, std op, cas 3, sequential, burst of 1
`define SDRAM_MODE_WORD {3'b000, 1'b1, 2'b00, 3'(`SDRAM_CAS_LATENCY), 1'b0, 3'b000}

`endif

// File: common/sdram_pkg.sv
/* chip command encodings, client ids, frame step type
   and the memory / multiplexed address layouts */
package sdram_pkg;

	// {ncs, nras, ncas, nwe}
	typedef enum logic [3:0] {
		cmd_inhibit      = 4'b1111,
		cmd_nop          = 4'b0111,
		cmd_active       = 4'b0011,
		cmd_read         = 4'b0101,
		cmd_write        = 4'b0100,
		cmd_precharge    = 4'b0010,
		cmd_auto_refresh = 4'b0001,
		cmd_load_mode    = 4'b0000
	} sdram_cmd_t;

	typedef enum logic [1:0] {
		client_none,
		client_rom,
		client_wram,
		client_vram
	} client_t;

	typedef logic [2:0] frame_step_t;

	// byte address into the chip
	typedef struct packed {
		logic [1:0]  bank;
		logic [12:0] row;
		logic [8:0]  col;
		logic        byte_sel; // high lane when set
	} mem_addr_t;

	// a bus carries the row at activate, the column at read/write
	typedef union packed {
		logic [12:0] row; // also mode word, precharge-all
		struct packed {
			logic [1:0] unused_hi;
			logic       auto_pre;  // a10
			logic       unused_lo;
			logic [8:0] col;
		} cas;
	} sdram_a_u;

endpackage

// File: design/frame_timer.sv
/* frame step counter, power-up countdown
   and refresh interval timer */
`include "sdram_settings.svh"

module frame_timer
	import sdram_pkg::*;
(
	input  logic        clk,
	input  logic        init_n,
	input  logic        refresh_issued, // restarts the interval
	output frame_step_t step,
	output logic        init,
	output logic [4:0]  init_count,
	output logic        need_refresh
);

	localparam frame_step_t last_step = 3'(`SDRAM_FRAME_STEPS - 1);

	logic [10:0] ref_count; // clocks since last refresh

	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			step <= '0;
		end else if (step == last_step) begin
			step <= '0;            // frame wrap
		end else begin
			step <= step + 3'd1;
		end
	end

	// countdown ticks once per frame, init drops a clock after 0
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			init_count <= `SDRAM_INIT_FRAMES;
			init       <= 1'b1;
		end else begin
			if (step == last_step && init_count != 5'd0)
				init_count <= init_count - 5'd1;
			init <= (init_count != 5'd0);
		end
	end

	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			ref_count    <= '0;
			need_refresh <= 1'b0;
		end else if (init || refresh_issued) begin
			ref_count    <= '0;
			need_refresh <= 1'b0;
		end else if (ref_count == `SDRAM_REFRESH_CYCLES) begin
			need_refresh <= 1'b1;  // count parks here until served
		end else begin
			ref_count <= ref_count + 11'd1;
		end
	end

	// no refresh demand may leak into the init sequence
	assert property (@(posedge clk) disable iff (!init_n)
		init |-> !need_refresh);

endmodule

// File: design/port_arbiter.sv
/* slot candidate selection, toggle request bookkeeping,
   ack flipping and read data routing per client */
module port_arbiter
	import sdram_pkg::*;
(
	input  logic        clk,
	input  logic        init_n,
	input  logic [21:1] rom_addr,
	input  logic [15:0] rom_din,
	input  logic        rom_req,
	input  logic        rom_we,
	input  logic [21:0] wram_addr,
	input  logic [7:0]  wram_din,
	input  logic        wram_req,
	input  logic        wram_we,
	input  logic [15:1] vram_addr,
	input  logic [15:0] vram_din,
	input  logic        vram_req,
	input  logic        vram_we,
	// from command_issue
	input  logic        take0, take1,
	input  logic        wr_done0, wr_done1,
	input  logic        rd_done0, rd_done1,
	input  logic [15:0] rd_data,
	// offers
	output logic        slot0_valid,
	output mem_addr_t   slot0_addr,
	output logic        slot0_we,
	output logic [15:0] slot0_din,
	output logic [1:0]  slot0_mask, // byte enables {hi, lo}
	output logic        slot1_valid,
	output mem_addr_t   slot1_addr,
	output logic        slot1_we,
	output logic [15:0] slot1_din,
	output logic [1:0]  slot1_mask,
	// client returns
	output logic [15:0] rom_dout,
	output logic        rom_ack,
	output logic [15:0] wram_dout,
	output logic        wram_ack,
	output logic [15:0] vram_dout,
	output logic        vram_ack
);

	logic      rom_state, wram_state, vram_state; // req as last taken
	logic      rom_pend, wram_pend, vram_pend;
	client_t   sel0;
	client_t   owner0, owner1;                      // who is in flight per slot
	mem_addr_t rom_word, wram_byte, vram_word;

	assign rom_pend  = rom_req ^ rom_state;
	assign wram_pend = wram_req ^ wram_state;
	assign vram_pend = vram_req ^ vram_state;

	// ----------------------------------------------------------
	// client regions
	assign rom_word  = {2'd0, 1'b0, rom_addr, 1'b0};   // bank 0, word aligned
	assign wram_byte = '{bank: 2'd0,
	                     row: 13'h080 + {1'b0, wram_addr[21:10]},
	                     col: wram_addr[9:1],
	                     byte_sel: wram_addr[0]};
	assign vram_word = {2'd3, 7'd0, vram_addr, 1'b0};  // bank 3

	// slot 0, rom first
	always_comb begin
		sel0       = client_none;
		slot0_addr = rom_word;
		slot0_we   = rom_we;
		slot0_din  = rom_din;
		slot0_mask = 2'b11;
		if (rom_pend) begin
			sel0 = client_rom;
		end else if (wram_pend) begin
			sel0       = client_wram;
			slot0_addr = wram_byte;
			slot0_we   = wram_we;
			slot0_din  = {wram_din, wram_din}; // same byte on both lanes
			if (wram_we)
				slot0_mask = wram_addr[0] ? 2'b10 : 2'b01;
		end
	end

	assign slot0_valid = (sel0 != client_none);

	// slot 1 has only vram
	assign slot1_valid = vram_pend;
	assign slot1_addr  = vram_word;
	assign slot1_we    = vram_we;
	assign slot1_din   = vram_din;
	assign slot1_mask  = 2'b11;

	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			rom_state  <= 1'b0;
			wram_state <= 1'b0;
			vram_state <= 1'b0;
			owner0     <= client_none;
			owner1     <= client_none;
			rom_ack    <= 1'b0;
			wram_ack   <= 1'b0;
			vram_ack   <= 1'b0;
		end else begin
			if (take0) begin
				owner0 <= sel0;
				if (sel0 == client_rom)
					rom_state <= rom_req;
				if (sel0 == client_wram)
					wram_state <= wram_req;
			end
			if (take1) begin
				owner1     <= client_vram;
				vram_state <= vram_req;
			end
			// done strobes refer to the previous owner
			if (wr_done0 || rd_done0) begin
				case (owner0)
					client_rom:  rom_ack  <= ~rom_ack;
					client_wram: wram_ack <= ~wram_ack;
					default: ;
				endcase
			end
			if ((wr_done1 || rd_done1) && owner1 == client_vram)
				vram_ack <= ~vram_ack;
		end
	end

	// read data, wram write echo
	always_ff @(posedge clk) begin
		if (take0 && sel0 == client_wram && wram_we) begin
			if (wram_addr[0])
				wram_dout[15:8] <= wram_din;
			else
				wram_dout[7:0] <= wram_din;
		end
		if (rd_done0 && owner0 == client_rom)
			rom_dout <= rd_data;
		if (rd_done0 && owner0 == client_wram)
			wram_dout <= rd_data;
		if (rd_done1 && owner1 == client_vram)
			vram_dout <= rd_data;
	end

	// an ack only moves toward a waiting req
	assert property (@(posedge clk) disable iff (!init_n)
		$changed(rom_ack) |-> $past(rom_req != rom_ack));
	assert property (@(posedge clk) disable iff (!init_n)
		$changed(wram_ack) |-> $past(wram_req != wram_ack));
	assert property (@(posedge clk) disable iff (!init_n)
		$changed(vram_ack) |-> $past(vram_req != vram_ack));

endmodule

// File: design/command_issue.sv
/* chip command sequencing for init, slot accesses and refresh
   plus data bus, masks and read capture */
`include "sdram_settings.svh"

module command_issue
	import sdram_pkg::*;
(
	input  logic        clk,
	input  logic        init_n,
	input  frame_step_t step,
	input  logic        init,
	input  logic [4:0]  init_count,
	input  logic        need_refresh,
	input  logic        slot0_valid,
	input  mem_addr_t   slot0_addr,
	input  logic        slot0_we,
	input  logic [15:0] slot0_din,
	input  logic [1:0]  slot0_mask,
	input  logic        slot1_valid,
	input  mem_addr_t   slot1_addr,
	input  logic        slot1_we,
	input  logic [15:0] slot1_din,
	input  logic [1:0]  slot1_mask,
	input  logic [15:0] sdram_dq_in,
	output logic        take0, take1,
	output logic        wr_done0, wr_done1,
	output logic        rd_done0, rd_done1,
	output logic [15:0] rd_data,
	output logic        refresh_issued,
	output sdram_cmd_t  cmd,
	output sdram_a_u    sdram_a,
	output logic [1:0]  sdram_ba,
	output logic [1:0]  sdram_dqm,
	output logic [15:0] dq_out,
	output logic        dq_oe
);

	// read masks open the step after cas
	localparam frame_step_t ds0_step = `SDRAM_CAS0_STEP + 3'd1;
	localparam frame_step_t ds1_step = `SDRAM_CAS1_STEP + 3'd1;

	logic        act0, act1;         // offer taken this frame
	logic        we0, we1;
	logic        rd_pend0, rd_pend1; // read out, data not yet in
	logic        cas0, cas1;
	logic        refresh_hold;       // keeps slot 0 off after refresh
	mem_addr_t   addr0, addr1;
	logic [15:0] din0, din1;
	logic [1:0]  mask0, mask1;

	assign take0 = !init && !refresh_hold && step == `SDRAM_RAS0_STEP && slot0_valid;
	assign take1 = !init && step == `SDRAM_RAS1_STEP && slot1_valid;
	assign cas0  = step == `SDRAM_CAS0_STEP && act0;
	assign cas1  = step == `SDRAM_CAS1_STEP && act1;
	assign wr_done0 = cas0 && we0;
	assign wr_done1 = cas1 && we1;

	// refresh in the slot 1 activate step, both slots idle
	assign refresh_issued = !init && step == `SDRAM_RAS1_STEP && need_refresh &&
		!slot1_valid && !act0;

	// ----------------------------------------------------------
	always_ff @(posedge clk or negedge init_n) begin
		if (!init_n) begin
			cmd          <= cmd_inhibit;
			sdram_dqm    <= 2'b11;
			dq_oe        <= 1'b0;
			act0         <= 1'b0;
			act1         <= 1'b0;
			rd_pend0     <= 1'b0;
			rd_pend1     <= 1'b0;
			rd_done0     <= 1'b0;
			rd_done1     <= 1'b0;
			refresh_hold <= 1'b0;
		end else begin
			cmd       <= cmd_nop;
			sdram_dqm <= 2'b11;
			dq_oe     <= 1'b0;
			rd_done0  <= step == `SDRAM_CAP0_STEP && rd_pend0;
			rd_done1  <= step == `SDRAM_CAP1_STEP && rd_pend1;
			if (init) begin
				if (step == `SDRAM_RAS0_STEP) begin
					case (init_count)
						`SDRAM_INIT_PRECHARGE: cmd <= cmd_precharge;
						`SDRAM_INIT_REFRESH_A: cmd <= cmd_auto_refresh;
						`SDRAM_INIT_REFRESH_B: cmd <= cmd_auto_refresh;
						`SDRAM_INIT_MODE:      cmd <= cmd_load_mode;
						default: ;
					endcase
				end
			end else begin
				// ras steps
				if (step == `SDRAM_RAS0_STEP)
					act0 <= take0;
				if (step == `SDRAM_RAS1_STEP) begin
					act1         <= take1;
					refresh_hold <= refresh_issued;
				end
				if (take0 || take1)
					cmd <= cmd_active;
				if (refresh_issued)
					cmd <= cmd_auto_refresh;

				// cas steps, auto precharge always set
				if (cas0) begin
					cmd      <= we0 ? cmd_write : cmd_read;
					rd_pend0 <= !we0;
					if (we0) begin
						dq_oe     <= 1'b1;
						sdram_dqm <= ~mask0;
					end
				end else if (step == `SDRAM_CAP0_STEP) begin
					rd_pend0 <= 1'b0;
				end
				if (cas1) begin
					cmd      <= we1 ? cmd_write : cmd_read;
					rd_pend1 <= !we1;
					if (we1) begin
						dq_oe     <= 1'b1;
						sdram_dqm <= ~mask1;
					end
				end else if (step == `SDRAM_CAP1_STEP) begin
					rd_pend1 <= 1'b0;
				end

				if (step == ds0_step && rd_pend0)
					sdram_dqm <= 2'b00;
				if (step == ds1_step && rd_pend1)
					sdram_dqm <= 2'b00;
			end
		end
	end

	// ----------------------------------------------------------
	// address, bank, write data and access latches
	always_ff @(posedge clk) begin
		if (init && step == `SDRAM_RAS0_STEP) begin
			if (init_count == `SDRAM_INIT_PRECHARGE)
				sdram_a.row <= 13'h0400;       // a10, all banks
			if (init_count == `SDRAM_INIT_MODE) begin
				sdram_a.row <= `SDRAM_MODE_WORD;
				sdram_ba    <= 2'd0;
			end
		end
		if (take0) begin
			addr0       <= slot0_addr;
			we0         <= slot0_we;
			din0        <= slot0_din;
			mask0       <= slot0_mask;
			sdram_a.row <= slot0_addr.row;
			sdram_ba    <= slot0_addr.bank;
		end
		if (take1) begin
			addr1       <= slot1_addr;
			we1         <= slot1_we;
			din1        <= slot1_din;
			mask1       <= slot1_mask;
			sdram_a.row <= slot1_addr.row;
			sdram_ba    <= slot1_addr.bank;
		end
		if (cas0) begin
			sdram_a.cas <= '{unused_hi: 2'b00, auto_pre: 1'b1, unused_lo: 1'b0,
			                 col: addr0.col};
			sdram_ba    <= addr0.bank;
			if (we0)
				dq_out <= din0;
		end
		if (cas1) begin
			sdram_a.cas <= '{unused_hi: 2'b00, auto_pre: 1'b1, unused_lo: 1'b0,
			                 col: addr1.col};
			sdram_ba    <= addr1.bank;
			if (we1)
				dq_out <= din1;
		end
		// registered dq sample at the capture step
		if ((step == `SDRAM_CAP0_STEP && rd_pend0) || (step == `SDRAM_CAP1_STEP && rd_pend1))
			rd_data <= sdram_dq_in;
	end

	// accesses wait for the whole power-up sequence
	assert property (@(posedge clk) disable iff (!init_n)
		init |=> !(cmd inside {cmd_active, cmd_read, cmd_write}));

	// bus driven only under a write command
	assert property (@(posedge clk) disable iff (!init_n)
		dq_oe |-> cmd == cmd_write);

endmodule

// File: design/sdram_ctrl.sv
/* controller top: frame timer, client arbiter
   and command issue wired to the chip pins */
module sdram_ctrl
	import sdram_pkg::*;
(
	input  logic        clk,
	input  logic        init_n,
	// chip pins
	inout  wire  [15:0] sdram_dq,
	output logic [12:0] sdram_a,
	output logic [1:0]  sdram_ba,
	output logic [1:0]  sdram_dqm,  // {dqmh, dqml}
	output logic        sdram_ncs,
	output logic        sdram_nras,
	output logic        sdram_ncas,
	output logic        sdram_nwe,
	// program memory, word wide
	input  logic [21:1] rom_addr,
	input  logic [15:0] rom_din,
	input  logic        rom_req,
	input  logic        rom_we,
	output logic [15:0] rom_dout,
	output logic        rom_ack,
	// work ram, byte wide
	input  logic [21:0] wram_addr,
	input  logic [7:0]  wram_din,
	input  logic        wram_req,
	input  logic        wram_we,
	output logic [15:0] wram_dout,
	output logic        wram_ack,
	// video ram
	input  logic [15:1] vram_addr,
	input  logic [15:0] vram_din,
	input  logic        vram_req,
	input  logic        vram_we,
	output logic [15:0] vram_dout,
	output logic        vram_ack
);

	frame_step_t step;
	logic        init;
	logic [4:0]  init_count;
	logic        need_refresh;
	logic        refresh_issued;

	// slot offers, arbiter -> command issue
	logic        slot0_valid, slot1_valid;
	mem_addr_t   slot0_addr, slot1_addr;
	logic        slot0_we, slot1_we;
	logic [15:0] slot0_din, slot1_din;
	logic [1:0]  slot0_mask, slot1_mask;

	// strobes back to the arbiter
	logic        take0, take1;
	logic        wr_done0, wr_done1;
	logic        rd_done0, rd_done1;
	logic [15:0] rd_data;

	sdram_cmd_t  cmd;
	sdram_a_u    a_bus;
	logic [15:0] dq_out;
	logic        dq_oe;

	frame_timer   timer0 (.*);
	port_arbiter  arb0 (.*);
	command_issue issue0 (.sdram_a(a_bus), .sdram_dq_in(sdram_dq), .*);

	assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = cmd;
	assign sdram_a  = a_bus;
	assign sdram_dq = dq_oe ? dq_out : 16'hzzzz; // released unless writing

endmodule

// File: bench/tb_clock.sv
/* testbench clock and power-on reset */
module tb_clock (
	output logic clk,
	output logic init_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk    = 1'b0;
		init_n = 1'b0; // held for 8 cycles
		repeat (8) @(posedge clk);
		#1 init_n = 1'b1;
	end

	always #2 clk = ~clk; // 4 ns period

endmodule

// File: bench/sdram_model.sv
/* behavioral sdram chip, cas latency 3, byte masks,
   sparse storage and a log of every issued command */
module sdram_model
	import sdram_pkg::*;
(
	input  logic        clk,
	inout  wire  [15:0] dq,
	input  logic [12:0] a,
	input  logic [1:0]  ba,
	input  logic [1:0]  dqm,
	input  logic        ncs,
	input  logic        nras,
	input  logic        ncas,
	input  logic        nwe
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [15:0] mem [logic [23:0]]; // {bank, row, col}
	logic [12:0] open_row [4];
	logic [2:0]  rd_v = 3'b000;      // read data pipeline
	logic [15:0] rd_d0, rd_d1, rd_d2;
	logic [15:0] drv = '0;
	logic        drv_en = 1'b0;
	longint      cycle = 0;
	sdram_cmd_t  cmd;
	logic [23:0] key;

	// command log, nop and inhibit left out
	sdram_cmd_t log_cmd [$];
	sdram_a_u   log_a [$];
	logic [1:0] log_ba [$];
	longint     log_cycle [$];

	assign cmd = sdram_cmd_t'({ncs, nras, ncas, nwe});
	assign key = {ba, open_row[ba], a[8:0]};
	assign dq  = drv_en ? drv : 16'hzzzz;

	// unwritten words read back a pattern of the whole address
	function automatic logic [15:0] fill_word(logic [23:0] k);
		return k[15:0] ^ {k[7:0], k[23:16]};
	endfunction

	always @(posedge clk) begin
		cycle <= cycle + 1;
		rd_v  <= {rd_v[1:0], cmd == cmd_read};
		rd_d0 <= mem.exists(key) ? mem[key] : fill_word(key);
		rd_d1 <= rd_d0;
		rd_d2 <= rd_d1;
		if (cmd != cmd_nop && cmd != cmd_inhibit) begin
			log_cmd.push_back(cmd);
			log_a.push_back(a);
			log_ba.push_back(ba);
			log_cycle.push_back(cycle);
		end
		if (cmd == cmd_active)
			open_row[ba] <= a;
		if (cmd == cmd_write) begin
			if (!mem.exists(key))
				mem[key] = fill_word(key);
			if (!dqm[0])
				mem[key][7:0] = dq[7:0];   // low lane enabled
			if (!dqm[1])
				mem[key][15:8] = dq[15:8];
		end
	end

	// data out one ns after the edge, valid at the third edge
	always @(posedge clk) begin
		#1;
		drv_en = rd_v[2];
		drv    = rd_d2;
	end

endmodule

// File: bench/tb_top.sv
/* controller testbench: init sequence, table driven client
   accesses, slot overlap and refresh spacing */
module tb_top
	import sdram_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	logic clk, init_n;
	wire  [15:0] sdram_dq;
	logic [12:0] sdram_a;
	logic [1:0]  sdram_ba, sdram_dqm;
	logic sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe;
	logic [21:1] rom_addr = '0;
	logic [15:0] rom_din = '0, rom_dout, wram_dout, vram_dout, vram_din = '0;
	logic [21:0] wram_addr = '0;
	logic [7:0]  wram_din = '0;
	logic [15:1] vram_addr = '0;
	logic rom_req = 0, rom_we = 0, wram_req = 0, wram_we = 0, vram_req = 0, vram_we = 0;
	logic rom_ack, wram_ack, vram_ack;

	// stimulus table, reads hold the expected word
	client_t     t_client [$];
	logic        t_we [$];
	logic [21:0] t_addr [$];
	logic [15:0] t_data [$];

	tb_clock    clk0 (.*);
	sdram_ctrl  dut0 (.*);
	sdram_model mem0 (.clk, .dq(sdram_dq), .a(sdram_a), .ba(sdram_ba), .dqm(sdram_dqm),
		.ncs(sdram_ncs), .nras(sdram_nras), .ncas(sdram_ncas), .nwe(sdram_nwe));

	task automatic stop_run(string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(string name, logic [15:0] exp, logic [15:0] act);
		if (exp !== act)
			stop_run($sformatf("[ERROR] %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_cmd(string name, sdram_cmd_t exp, sdram_cmd_t act);
		if (exp !== act)
			stop_run($sformatf("[ERROR] %s expected %s actual %s", name, exp.name(), act.name()));
	endtask

	task automatic check_addr(string name, sdram_a_u exp, sdram_a_u act);
		if (exp !== act)
			stop_run($sformatf("[ERROR] %s expected %h actual %h", name, exp.row, act.row));
	endtask

	task automatic add_row(client_t c, logic we, logic [21:0] addr, logic [15:0] data);
		t_client.push_back(c);
		t_we.push_back(we);
		t_addr.push_back(addr);
		t_data.push_back(data);
	endtask

	// sets the port and toggles req, caller aligns to the clock
	task automatic start_req(client_t c, logic we, logic [21:0] addr, logic [15:0] data);
		case (c)
			client_rom: begin
				rom_addr = addr[21:1];
				rom_din  = data;
				rom_we   = we;
				rom_req  = ~rom_req;
			end
			client_wram: begin
				wram_addr = addr;
				wram_din  = data[7:0];
				wram_we   = we;
				wram_req  = ~wram_req;
			end
			default: begin
				vram_addr = addr[15:1];
				vram_din  = data;
				vram_we   = we;
				vram_req  = ~vram_req;
			end
		endcase
	endtask

	task automatic wait_ack(client_t c);
		int n;
		for (n = 0; n < 200; n++) begin
			if ((c == client_rom && rom_ack == rom_req) ||
			    (c == client_wram && wram_ack == wram_req) ||
			    (c == client_vram && vram_ack == vram_req))
				return;
			@(posedge clk);
			#1;
		end
		stop_run($sformatf("no ack from the %s port within 200 cycles", c.name()));
	endtask

	task automatic run_row(int i);
		string name;
		logic [15:0] got;
		name = $sformatf("row %0d %s", i, t_client[i].name());
		@(posedge clk);
		#1;
		start_req(t_client[i], t_we[i], t_addr[i], t_data[i]);
		wait_ack(t_client[i]);
		got = t_client[i] == client_rom ? rom_dout :
		      t_client[i] == client_wram ? wram_dout : vram_dout;
		if (t_client[i] == client_wram && t_we[i]) // written byte in its lane
			check_word(name, t_data[i][7:0], t_addr[i][0] ? got[15:8] : got[7:0]);
		else if (!t_we[i])
			check_word(name, t_data[i], got);
	endtask

	initial begin
		int i, n, refs, first, base;
		longint last;
		logic [15:0] r [6];
		logic [7:0]  lo, hi;
		logic        seen0, seen3;
		void'($urandom(32'h1d48));
		foreach (r[k])
			r[k] = 16'($urandom);
		lo = 8'($urandom);
		hi = 8'($urandom);

		// ------------------------------------------------------------
		// power-up sequence, log entries from reset release on
		n = 0;
		while (init_n !== 1'b1) begin
			if (n++ >= 20)
				stop_run("reset was not released within 20 cycles");
			@(posedge clk);
			#1;
		end
		base = mem0.log_cmd.size();
		n = 0;
		while (dut0.init) begin
			if (n++ >= 400)
				stop_run("init did not end within 400 cycles");
			@(posedge clk);
			#1;
		end
		if (mem0.log_cmd.size() < base + 4)
			stop_run("fewer than four init commands were logged");
		check_cmd("init precharge", cmd_precharge, mem0.log_cmd[base]);
		check_addr("init precharge a10", 13'h0400, mem0.log_a[base]);
		check_cmd("init refresh a", cmd_auto_refresh, mem0.log_cmd[base + 1]);
		check_cmd("init refresh b", cmd_auto_refresh, mem0.log_cmd[base + 2]);
		check_cmd("init load mode", cmd_load_mode, mem0.log_cmd[base + 3]);
		// single writes, std op, cas 3, sequential, burst of 1
		check_addr("mode word", 13'h0230, mem0.log_a[base + 3]);

		// ------------------------------------------------------------
		// table: rom, wram bytes, vram
		add_row(client_rom, 1, 22'h000010, r[0]);
		add_row(client_rom, 1, 22'h012346, r[1]);
		add_row(client_rom, 1, 22'h0ffffe, r[2]);
		add_row(client_rom, 0, 22'h000010, r[0]);
		add_row(client_rom, 0, 22'h012346, r[1]);
		add_row(client_rom, 0, 22'h0ffffe, r[2]);
		add_row(client_wram, 1, 22'h000100, {8'h00, lo});
		add_row(client_wram, 1, 22'h000101, {8'h00, hi});
		add_row(client_wram, 0, 22'h000100, {hi, lo});
		add_row(client_vram, 1, 22'h000020, r[3]);
		add_row(client_vram, 1, 22'h00fffe, r[4]);
		add_row(client_vram, 0, 22'h000020, r[3]);
		add_row(client_vram, 0, 22'h00fffe, r[4]);
		for (i = 0; i < t_client.size(); i++)
			run_row(i);

		// ------------------------------------------------------------
		// rom read and vram write launched together
		first = mem0.log_cmd.size();
		@(posedge clk);
		#1;
		start_req(client_rom, 0, 22'h012346, '0);
		start_req(client_vram, 1, 22'h000020, r[5]);
		wait_ack(client_rom);
		wait_ack(client_vram);
		check_word("overlap rom read", r[1], rom_dout);
		seen0 = 0;
		seen3 = 0;
		for (i = first; i < mem0.log_cmd.size(); i++) begin
			if (mem0.log_cmd[i] == cmd_active && mem0.log_ba[i] == 2'd0) seen0 = 1;
			if (mem0.log_cmd[i] == cmd_active && mem0.log_ba[i] == 2'd3) seen3 = 1;
		end
		if (!(seen0 && seen3))
			stop_run("overlapped accesses did not activate banks 0 and 3");
		t_client.delete();
		t_we.delete();
		t_addr.delete();
		t_data.delete();
		add_row(client_vram, 0, 22'h000020, r[5]);
		run_row(0);

		// ------------------------------------------------------------
		// idle, refresh spacing, data kept
		first = mem0.log_cmd.size();
		repeat (3000) @(posedge clk);
		#1;
		refs = 0;
		last = 0;
		for (i = first; i < mem0.log_cmd.size(); i++) begin
			if (mem0.log_cmd[i] != cmd_auto_refresh)
				continue;
			if (refs > 0 && (mem0.log_cycle[i] - last < 1000 || mem0.log_cycle[i] - last > 1008))
				stop_run($sformatf("refreshes %0d clocks apart", mem0.log_cycle[i] - last));
			last = mem0.log_cycle[i];
			refs++;
		end
		if (refs < 2)
			stop_run($sformatf("only %0d refreshes in 3000 idle cycles", refs));
		add_row(client_rom, 0, 22'h0ffffe, r[2]);
		add_row(client_wram, 0, 22'h000100, {hi, lo});
		add_row(client_vram, 0, 22'h00fffe, r[4]);
		for (i = 1; i < t_client.size(); i++)
			run_row(i);

		$display("Regression passed");
		$finish;
	end

endmodule

// File: files.f
+incdir+common
common/sdram_pkg.sv
design/frame_timer.sv
design/port_arbiter.sv
design/command_issue.sv
design/sdram_ctrl.sv
bench/tb_clock.sv
bench/sdram_model.sv
bench/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_top -f files.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0
